//--- Makefile
# Verilator build and run of the rx digital core testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

FAIL_MSG := >>> FAIL
PASS_MSG := >>> PASS

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  build  compile the testbench and RTL with Verilator"
	@echo "  test   build, run the simulation into $(LOG) and report the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/adc_frontend.sv
`timescale 1ns/10ps

module adc_frontend #(
    parameter int n_lanes = 16,
    parameter int n_banks = 4
) (
    input  logic              clk_adc,
    input  logic              cdr_rstb,
    input  rx_pack::adc_mag_t adc_mag_i  [n_lanes-1:0],
    input  logic              adc_sign_i [n_lanes-1:0],
    input  logic              en_cal_i,
    input  rx_pack::ndiv_t    ndiv_i,
    output rx_pack::code_t    code_o     [n_lanes-1:0]
);
    localparam int lanes_per_bank = n_lanes / n_banks;
    localparam int cnt_w = 2**$bits(rx_pack::ndiv_t) - 1;

    rx_pack::adc_mag_t mag_q  [n_lanes-1:0];
    logic              sign_q [n_lanes-1:0];
    logic [cnt_w-1:0]  avg_cnt_q;
    logic [cnt_w-1:0]  avg_mask;
    logic              period_end;
    logic              update_q;

    ////////////////////////////////////////////////////////////
    // frame register with bank transpose
    ////////////////////////////////////////////////////////////

    for (genvar gb = 0; gb < n_banks; gb++) begin : g_bank
        for (genvar gs = 0; gs < lanes_per_bank; gs++) begin : g_slot
            localparam int src = gb * lanes_per_bank + gs;
            localparam int dst = gs * n_banks + gb;

            always_ff @(posedge clk_adc or negedge cdr_rstb) begin
                if (!cdr_rstb) begin
                    mag_q[dst]  <= '0;
                    sign_q[dst] <= 1'b0;
                end else begin
                    mag_q[dst]  <= adc_mag_i[src];
                    sign_q[dst] <= adc_sign_i[src];
                end
            end
        end
    end

    // averaging pulse, one cycle in every 2**ndiv
    always_comb begin
        avg_mask   = {cnt_w{1'b1}} >> (cnt_w - int'(ndiv_i));
        period_end = (avg_cnt_q >= avg_mask);
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            avg_cnt_q <= '0;
            update_q  <= 1'b0;
        end else begin
            avg_cnt_q <= period_end ? '0 : avg_cnt_q + 1'b1;
            update_q  <= period_end;
        end
    end

    for (genvar k = 0; k < n_lanes; k++) begin : g_unfold
        adc_unfold_cal u_unfold (
            .clk_adc  (clk_adc),
            .cdr_rstb (cdr_rstb),
            .mag_i    (mag_q[k]),
            .sign_i   (sign_q[k]),
            .update_i (update_q),
            .en_cal_i (en_cal_i),
            .ndiv_i   (ndiv_i),
            .code_o   (code_o[k])
        );
    end

endmodule

//--- logic/adc_unfold_cal.sv
`timescale 1ns/10ps

module adc_unfold_cal (
    input  logic              clk_adc,
    input  logic              cdr_rstb,
    input  rx_pack::adc_mag_t mag_i,
    input  logic              sign_i,
    input  logic              update_i,
    input  logic              en_cal_i,
    input  rx_pack::ndiv_t    ndiv_i,
    output rx_pack::code_t    code_o
);
    // room for 2**15 codes in the running sum
    localparam int sum_w  = rx_pack::code_w + 2**$bits(rx_pack::ndiv_t) - 1;
    localparam int diff_w = rx_pack::code_w + 1;

    typedef logic signed [sum_w-1:0] cal_sum_t;

    localparam rx_pack::code_t code_max = {1'b0, {(rx_pack::code_w-1){1'b1}}};
    localparam rx_pack::code_t code_min = {1'b1, {(rx_pack::code_w-1){1'b0}}};

    rx_pack::code_t           mag_ext;
    rx_pack::code_t           raw_code;
    cal_sum_t                 sum_q;
    cal_sum_t                 sum_next;
    rx_pack::code_t           offset_q;
    logic signed [diff_w-1:0] diff;
    rx_pack::code_t           code_sat;

    ////////////////////////////////////////////////////////////
    // sign/magnitude unfolding
    ////////////////////////////////////////////////////////////

    always_comb begin
        mag_ext  = rx_pack::code_t'({1'b0, mag_i});
        raw_code = sign_i ? mag_ext : -mag_ext;
    end

    // current sample closes the period on the update cycle
    assign sum_next = sum_q + cal_sum_t'(raw_code);

    // offset removal, one extra bit to catch overflow
    always_comb begin
        diff = {raw_code[rx_pack::code_w-1], raw_code}
             - {offset_q[rx_pack::code_w-1], offset_q};

        if (diff[diff_w-1] == diff[diff_w-2]) begin
            code_sat = diff[rx_pack::code_w-1:0];
        end else if (diff[diff_w-1]) begin
            code_sat = code_min;
        end else begin
            code_sat = code_max;
        end
    end

    ////////////////////////////////////////////////////////////
    // offset averaging
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            sum_q    <= '0;
            offset_q <= '0;
        end else if (!en_cal_i) begin
            // calibration off, no offset
            sum_q    <= '0;
            offset_q <= '0;
        end else if (update_i) begin
            offset_q <= rx_pack::code_t'(sum_next >>> ndiv_i);
            sum_q    <= '0;
        end else begin
            sum_q <= sum_next;
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            code_o <= '0;
        end else begin
            code_o <= code_sat;
        end
    end

endmodule

//--- logic/mm_cdr_loop.sv
`timescale 1ns/10ps

module mm_cdr_loop #(
    parameter int n_lanes = 16
) (
    input  logic             clk_adc,
    input  logic             cdr_rstb,
    input  rx_pack::code_t   code_i [n_lanes-1:0],
    input  rx_pack::sym_t    sym_i  [n_lanes-1:0],
    input  logic [3:0]       gain_shift_i,
    output logic             ctl_valid_o,
    output rx_pack::pi_ctl_t phase_o
);
    localparam int wait_w = $clog2(rx_pack::wait_cycles);
    localparam int err_w  = rx_pack::code_w + $bits(rx_pack::sym_t) + 1;
    localparam int acc_w  = $bits(rx_pack::phase_acc_t);

    rx_pack::cdr_state_t state_q;
    logic [wait_w-1:0]   wait_cnt_q;
    rx_pack::code_t      code_d [n_lanes-1:0];
    rx_pack::code_t      prev_code_q;
    rx_pack::sym_t       prev_sym_q;
    rx_pack::pd_sum_t    pd_sum_d;
    rx_pack::pd_sum_t    pd_sum_q;
    rx_pack::phase_acc_t acc_step;
    rx_pack::phase_acc_t acc_q;

    ////////////////////////////////////////////////////////////
    // post-reset wait
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q    <= rx_pack::CDR_WAIT;
            wait_cnt_q <= '0;
        end else if (state_q == rx_pack::CDR_WAIT) begin
            if (wait_cnt_q == wait_w'(rx_pack::wait_cycles - 1)) begin
                state_q <= rx_pack::CDR_RUN;
            end else begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end
        end
    end

    assign ctl_valid_o = (state_q == rx_pack::CDR_RUN);

    // mueller-muller error, lane 0 looks back into the previous frame
    always_comb begin
        int                       left;
        rx_pack::code_t           code_l;
        rx_pack::sym_t            sym_l;
        logic signed [err_w-1:0]  err;

        pd_sum_d = '0;
        for (int k = 0; k < n_lanes; k++) begin
            left   = (k + n_lanes - 1) % n_lanes;
            code_l = (k == 0) ? prev_code_q : code_d[left];
            sym_l  = (k == 0) ? prev_sym_q : sym_i[left];
            err    = code_d[k] * sym_l - code_l * sym_i[k];
            pd_sum_d = pd_sum_d + rx_pack::pd_sum_t'(err);
        end
    end

    assign acc_step = rx_pack::phase_acc_t'(pd_sum_q >>> gain_shift_i);

    ////////////////////////////////////////////////////////////
    // code alignment, error sum and phase accumulator
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            for (int k = 0; k < n_lanes; k++) begin
                code_d[k] <= '0;
            end
            prev_code_q <= '0;
            prev_sym_q  <= '0;
            pd_sum_q    <= '0;
            acc_q       <= '0;
        end else begin
            code_d      <= code_i;
            prev_code_q <= code_d[n_lanes-1];
            prev_sym_q  <= sym_i[n_lanes-1];
            pd_sum_q    <= pd_sum_d;
            // wraps on overflow
            if (state_q == rx_pack::CDR_RUN) begin
                acc_q <= acc_q + acc_step;
            end
        end
    end

    assign phase_o = acc_q[acc_w-1 -: rx_pack::pi_w];

endmodule

//--- logic/pam4_slicer.sv
`timescale 1ns/10ps

module pam4_slicer #(
    parameter int n_lanes = 16
) (
    input  logic              clk_adc,
    input  logic              cdr_rstb,
    input  rx_pack::code_t    code_i    [n_lanes-1:0],
    input  rx_pack::code_t    slice_lo_i,
    input  rx_pack::code_t    slice_mid_i,
    input  rx_pack::code_t    slice_hi_i,
    output rx_pack::sym_t     sym_o     [n_lanes-1:0],
    output rx_pack::rx_bits_t rx_bits_o [n_lanes-1:0]
);
    localparam rx_pack::sym_t sym_p3 = 3;
    localparam rx_pack::sym_t sym_p1 = 1;
    localparam rx_pack::sym_t sym_n1 = -1;
    localparam rx_pack::sym_t sym_n3 = -3;

    for (genvar k = 0; k < n_lanes; k++) begin : g_lane
        rx_pack::sym_t     sym_d;
        rx_pack::rx_bits_t bits_d;

        // strict compare against each level
        always_comb begin
            if (code_i[k] > slice_hi_i) begin
                sym_d  = sym_p3;
                bits_d = 2'b10;
            end else if (code_i[k] > slice_mid_i) begin
                sym_d  = sym_p1;
                bits_d = 2'b11;
            end else if (code_i[k] > slice_lo_i) begin
                sym_d  = sym_n1;
                bits_d = 2'b01;
            end else begin
                sym_d  = sym_n3;
                bits_d = 2'b00;
            end
        end

        // reset state matches the -3 decision
        always_ff @(posedge clk_adc or negedge cdr_rstb) begin
            if (!cdr_rstb) begin
                sym_o[k]     <= sym_n3;
                rx_bits_o[k] <= 2'b00;
            end else begin
                sym_o[k]     <= sym_d;
                rx_bits_o[k] <= bits_d;
            end
        end
    end

endmodule

//--- logic/pi_ctl_map.sv
`timescale 1ns/10ps

module pi_ctl_map #(
    parameter int n_pi = 4
) (
    input  logic              clk_adc,
    input  logic              cdr_rstb,
    input  rx_pack::pi_ctl_t  phase_i,
    input  rx_pack::max_sel_t max_sel_i   [n_pi-1:0],
    input  rx_pack::pi_ctl_t  pi_offset_i [n_pi-1:0],
    output rx_pack::pi_ctl_t  pi_ctl_o    [n_pi-1:0]
);
    localparam rx_pack::pi_ctl_t one = rx_pack::pi_ctl_t'(1);

    for (genvar j = 0; j < n_pi; j++) begin : g_pi
        rx_pack::pi_ctl_t scale;
        rx_pack::pi_ctl_t wrapped;

        // range is 16 codes per select step, minus one
        always_comb begin
            scale   = ((rx_pack::pi_ctl_t'(max_sel_i[j]) + one) << 4) - one;
            wrapped = phase_i % scale;
        end

        always_ff @(posedge clk_adc or negedge cdr_rstb) begin
            if (!cdr_rstb) begin
                pi_ctl_o[j] <= '0;
            end else begin
                pi_ctl_o[j] <= wrapped + pi_offset_i[j];
            end
        end
    end

endmodule

//--- logic/rx_digital_core.sv
`timescale 1ns/10ps

module rx_digital_core #(
    parameter int n_lanes = 16,
    parameter int n_banks = 4,
    parameter int n_pi    = 4
) (
    input  logic              clk_adc,
    input  logic              cdr_rstb,
    input  rx_pack::adc_mag_t adc_mag_i   [n_lanes-1:0],
    input  logic              adc_sign_i  [n_lanes-1:0],
    input  logic              en_cal_i,
    input  rx_pack::ndiv_t    ndiv_i,
    input  rx_pack::code_t    slice_lo_i,
    input  rx_pack::code_t    slice_mid_i,
    input  rx_pack::code_t    slice_hi_i,
    input  logic [3:0]        gain_shift_i,
    input  rx_pack::max_sel_t max_sel_i   [n_pi-1:0],
    input  rx_pack::pi_ctl_t  pi_offset_i [n_pi-1:0],
    output rx_pack::rx_bits_t rx_bits_o   [n_lanes-1:0],
    output logic              ctl_valid_o,
    output rx_pack::pi_ctl_t  pi_ctl_o    [n_pi-1:0]
);
    rx_pack::code_t   lane_code [n_lanes-1:0];
    rx_pack::sym_t    lane_sym  [n_lanes-1:0];
    rx_pack::pi_ctl_t phase_word;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    adc_frontend #(
        .n_lanes (n_lanes),
        .n_banks (n_banks)
    ) u_frontend (
        .clk_adc    (clk_adc),
        .cdr_rstb   (cdr_rstb),
        .adc_mag_i  (adc_mag_i),
        .adc_sign_i (adc_sign_i),
        .en_cal_i   (en_cal_i),
        .ndiv_i     (ndiv_i),
        .code_o     (lane_code)
    );

    pam4_slicer #(
        .n_lanes (n_lanes)
    ) u_slicer (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .code_i      (lane_code),
        .slice_lo_i  (slice_lo_i),
        .slice_mid_i (slice_mid_i),
        .slice_hi_i  (slice_hi_i),
        .sym_o       (lane_sym),
        .rx_bits_o   (rx_bits_o)
    );

    ////////////////////////////////////////////////////////////
    // clock recovery and interpolator control
    ////////////////////////////////////////////////////////////

    mm_cdr_loop #(
        .n_lanes (n_lanes)
    ) u_cdr (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .code_i       (lane_code),
        .sym_i        (lane_sym),
        .gain_shift_i (gain_shift_i),
        .ctl_valid_o  (ctl_valid_o),
        .phase_o      (phase_word)
    );

    pi_ctl_map #(
        .n_pi (n_pi)
    ) u_pi_map (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .phase_i     (phase_word),
        .max_sel_i   (max_sel_i),
        .pi_offset_i (pi_offset_i),
        .pi_ctl_o    (pi_ctl_o)
    );

endmodule

//--- logic/rx_pack.sv
package rx_pack;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    // adc magnitude, without the sign bit
    localparam int adc_w = 8;

    // unfolded code carries the sign on top of the magnitude
    localparam int code_w = adc_w + 1;

    // phase interpolator control word
    localparam int pi_w = 9;

    // cycles between reset release and loop start
    localparam int wait_cycles = 32;

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    typedef logic        [adc_w-1:0]  adc_mag_t;
    typedef logic signed [code_w-1:0] code_t;

    // pam4 levels -3, -1, +1, +3
    typedef logic signed [2:0]        sym_t;

    // gray coded decision
    typedef logic        [1:0]        rx_bits_t;

    typedef logic        [pi_w-1:0]   pi_ctl_t;
    typedef logic        [4:0]        max_sel_t;

    // averaging period is 2**ndiv cycles
    typedef logic        [3:0]        ndiv_t;

    typedef logic signed [19:0]       pd_sum_t;

    // phase word is taken from the top pi_w bits
    typedef logic signed [23:0]       phase_acc_t;

    // clock recovery loop states
    typedef enum logic {
        CDR_WAIT,
        CDR_RUN
    } cdr_state_t;

endpackage

//--- sim/rx_core_props.sv
`timescale 1ns/10ps

module rx_core_props #(
    parameter int n_lanes = 16,
    parameter int n_pi    = 4
) (
    input logic                clk_adc,
    input logic                cdr_rstb,
    input logic                ctl_valid_i,
    input rx_pack::cdr_state_t state_i,
    input rx_pack::rx_bits_t   rx_bits_i [n_lanes-1:0],
    input rx_pack::pi_ctl_t    pi_ctl_i  [n_pi-1:0]
);

    // loop enable holds until the next reset
    valid_sticky: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) ctl_valid_i |=> ctl_valid_i
    ) else $error("ctl_valid_o fell without a reset");

    run_matches_valid: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
            (state_i == rx_pack::CDR_RUN) == ctl_valid_i
    ) else $error("loop state and ctl_valid_o disagree");

    for (genvar k = 0; k < n_lanes; k++) begin : g_bits
        bits_known: assert property (
            @(posedge clk_adc) disable iff (!cdr_rstb) !$isunknown(rx_bits_i[k])
        ) else $error("rx_bits_o[%0d] is unknown", k);
    end

    for (genvar j = 0; j < n_pi; j++) begin : g_pi
        pi_known: assert property (
            @(posedge clk_adc) disable iff (!cdr_rstb) !$isunknown(pi_ctl_i[j])
        ) else $error("pi_ctl_o[%0d] is unknown", j);
    end

endmodule

//--- sim/tb_rx_core.sv
`timescale 1ns/10ps

module tb_rx_core;

    localparam int  n_lanes    = 16;
    localparam int  n_banks    = 2;
    localparam int  n_pi       = 4;
    localparam int  lanes_per_bank = n_lanes / n_banks;
    localparam time clk_period = 100ns;
    localparam int  rst_cycles = 10;
    localparam int  wait_edges = 32;

    localparam int slice_frames = 64;
    localparam int cal_level    = 40;
    localparam int cal_ndiv     = 3;
    localparam int quiet_steps  = 4;
    localparam int track_cycles = 400;
    localparam int track_shift  = 1;
    localparam int track_base [4] = '{255, 9, -255, -9};
    localparam int track_sel  [4] = '{0, 1, 2, 31};
    localparam int track_off  [4] = '{0, 40, 300, 480};

    // cycles per test including reset
    localparam int len_wait  = rst_cycles + 2 + wait_edges + 9;
    localparam int len_slice = rst_cycles + 2 + slice_frames + 3;
    localparam int len_cal   = rst_cycles + 2 + (3 << cal_ndiv) + 3 + 8;
    localparam int len_quiet = rst_cycles + 2 + wait_edges + 8 + quiet_steps * 4;
    localparam int len_track = rst_cycles + 2 + track_cycles;
    localparam int run_cycles = len_wait + len_slice + len_cal + len_quiet + len_track;

    logic              clk_adc = 1'b0;
    logic              cdr_rstb;
    rx_pack::adc_mag_t adc_mag_i   [n_lanes-1:0];
    logic              adc_sign_i  [n_lanes-1:0];
    logic              en_cal_i;
    rx_pack::ndiv_t    ndiv_i;
    rx_pack::code_t    slice_lo_i;
    rx_pack::code_t    slice_mid_i;
    rx_pack::code_t    slice_hi_i;
    logic [3:0]        gain_shift_i;
    rx_pack::max_sel_t max_sel_i   [n_pi-1:0];
    rx_pack::pi_ctl_t  pi_offset_i [n_pi-1:0];
    rx_pack::rx_bits_t rx_bits_o   [n_lanes-1:0];
    logic              ctl_valid_o;
    rx_pack::pi_ctl_t  pi_ctl_o    [n_pi-1:0];

    int seed   = 32'h6df7b9ab;
    int errors = 0;
    int checks = 0;

    // codes wanted on the output lanes of the next frame
    int frame_code [n_lanes];
    int pattern    [n_lanes];

    rx_digital_core #(
        .n_lanes (n_lanes),
        .n_banks (n_banks),
        .n_pi    (n_pi)
    ) dut0 (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .adc_mag_i    (adc_mag_i),
        .adc_sign_i   (adc_sign_i),
        .en_cal_i     (en_cal_i),
        .ndiv_i       (ndiv_i),
        .slice_lo_i   (slice_lo_i),
        .slice_mid_i  (slice_mid_i),
        .slice_hi_i   (slice_hi_i),
        .gain_shift_i (gain_shift_i),
        .max_sel_i    (max_sel_i),
        .pi_offset_i  (pi_offset_i),
        .rx_bits_o    (rx_bits_o),
        .ctl_valid_o  (ctl_valid_o),
        .pi_ctl_o     (pi_ctl_o)
    );

    bind rx_digital_core rx_core_props #(
        .n_lanes (n_lanes),
        .n_pi    (n_pi)
    ) props0 (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .ctl_valid_i (ctl_valid_o),
        .state_i     (u_cdr.state_q),
        .rx_bits_i   (rx_bits_o),
        .pi_ctl_i    (pi_ctl_o)
    );

    always #(clk_period / 2) clk_adc = ~clk_adc;

    initial begin
        #(clk_period * (run_cycles + 20));
        $display("watchdog expired after %0d cycles, tests did not finish", run_cycles + 20);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////

    // bank transpose from input lane to output lane
    function automatic int lane_dest(int i);
        return (i % lanes_per_bank) * n_banks + i / lanes_per_bank;
    endfunction

    function automatic int slice_level(int code, int lo, int mid, int hi);
        if (code > hi) begin
            return 3;
        end else if (code > mid) begin
            return 1;
        end else if (code > lo) begin
            return -1;
        end
        return -3;
    endfunction

    function automatic logic [1:0] gray_bits(int sym);
        case (sym)
            3:       return 2'b10;
            1:       return 2'b11;
            -1:      return 2'b01;
            default: return 2'b00;
        endcase
    endfunction

    // mm error of one pattern frame after a frame of opposite polarity
    function automatic int frame_error(int pol);
        int cur_c;
        int left_c;
        int sum;
        sum = 0;
        for (int k = 0; k < n_lanes; k++) begin
            cur_c  = pol * pattern[k];
            left_c = (k == 0) ? -pol * pattern[n_lanes-1] : pol * pattern[k-1];
            sum += cur_c * slice_level(left_c, -64, 0, 64)
                 - left_c * slice_level(cur_c, -64, 0, 64);
        end
        return sum;
    endfunction

    function automatic int pi_expect(int acc, int sel, int off);
        int scale;
        scale = (sel + 1) * 16 - 1;
        return ((acc >> 15) % scale + off) % 512;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_adc);
        cdr_rstb <= 1'b0;
        repeat (rst_cycles) @(posedge clk_adc);
        cdr_rstb <= 1'b1;
    endtask

    // sign/magnitude on the input lane that lands on each output lane
    task automatic drive_frame();
        int c;
        for (int i = 0; i < n_lanes; i++) begin
            c = frame_code[lane_dest(i)];
            adc_sign_i[i] <= (c >= 0);
            adc_mag_i[i]  <= rx_pack::adc_mag_t'((c < 0) ? -c : c);
        end
    endtask

    task automatic set_slices(int lo, int mid, int hi);
        slice_lo_i  <= rx_pack::code_t'(lo);
        slice_mid_i <= rx_pack::code_t'(mid);
        slice_hi_i  <= rx_pack::code_t'(hi);
    endtask

    task automatic wait_valid(int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk_adc);
            n++;
        end while (!ctl_valid_o && n < limit);
        checks++;
        assert (ctl_valid_o) else begin
            errors++;
            $display("ctl_valid_o did not rise within %0d cycles", limit);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_wait();
        apply_reset();
        for (int j = 0; j < n_pi; j++) begin
            max_sel_i[j]   <= rx_pack::max_sel_t'(j * 9);
            pi_offset_i[j] <= rx_pack::pi_ctl_t'($random(seed));
        end
        // zero codes keep the loop quiet
        for (int k = 0; k < n_lanes; k++) begin
            frame_code[k] = 0;
        end
        drive_frame();
        for (int e = 0; e <= wait_edges + 8; e++) begin
            @(negedge clk_adc);
            check_value("ctl_valid_o", ctl_valid_o, e >= wait_edges);
            for (int j = 0; j < n_pi && e > 0; j++) begin
                check_value($sformatf("pi_ctl_o[%0d]", j), pi_ctl_o[j], pi_offset_i[j]);
            end
        end
    endtask

    task automatic test_slice();
        logic [1:0] exp_bits [slice_frames][n_lanes];
        apply_reset();
        en_cal_i <= 1'b0;
        set_slices(-80, 5, 90);
        for (int n = 0; n < slice_frames + 3; n++) begin
            @(posedge clk_adc);
            if (n < slice_frames) begin
                for (int k = 0; k < n_lanes; k++) begin
                    frame_code[k]  = $random(seed) % 256;
                    exp_bits[n][k] = gray_bits(slice_level(frame_code[k], -80, 5, 90));
                end
                drive_frame();
            end
            @(negedge clk_adc);
            for (int k = 0; k < n_lanes && n >= 3; k++) begin
                check_value($sformatf("rx_bits_o[%0d]", k), rx_bits_o[k], exp_bits[n-3][k]);
            end
        end
    endtask

    task automatic test_cal();
        int cal_code;
        apply_reset();
        en_cal_i <= 1'b1;
        ndiv_i   <= rx_pack::ndiv_t'(cal_ndiv);
        set_slices(-64, 0, 64);
        for (int k = 0; k < n_lanes; k++) begin
            frame_code[k] = cal_level;
        end
        drive_frame();
        // learned offset is the period average
        cal_code = cal_level - (((1 << cal_ndiv) * cal_level) >>> cal_ndiv);
        repeat ((3 << cal_ndiv) + 3) @(posedge clk_adc);
        for (int n = 0; n < 8; n++) begin
            @(negedge clk_adc);
            for (int k = 0; k < n_lanes; k++) begin
                check_value($sformatf("rx_bits_o[%0d]", k), rx_bits_o[k],
                            gray_bits(slice_level(cal_code, -64, 0, 64)));
            end
        end
        @(posedge clk_adc);
        en_cal_i <= 1'b0;
    endtask

    task automatic test_quiet();
        apply_reset();
        set_slices(-64, 0, 64);
        gain_shift_i <= 4'd0;
        for (int k = 0; k < n_lanes; k++) begin
            frame_code[k] = 100;
        end
        drive_frame();
        wait_valid(wait_edges + 8);
        for (int s = 0; s < quiet_steps; s++) begin
            @(posedge clk_adc);
            for (int j = 0; j < n_pi; j++) begin
                max_sel_i[j]   <= rx_pack::max_sel_t'(s * 11 + j * 7);
                pi_offset_i[j] <= rx_pack::pi_ctl_t'($random(seed));
            end
            repeat (2) @(posedge clk_adc);
            @(negedge clk_adc);
            for (int j = 0; j < n_pi; j++) begin
                check_value($sformatf("pi_ctl_o[%0d]", j), pi_ctl_o[j], pi_offset_i[j]);
            end
        end
    endtask

    task automatic test_track();
        int acc;
        int acc_prev;
        int pol;
        apply_reset();
        set_slices(-64, 0, 64);
        gain_shift_i <= 4'(track_shift);
        for (int j = 0; j < n_pi; j++) begin
            max_sel_i[j]   <= rx_pack::max_sel_t'(track_sel[j]);
            pi_offset_i[j] <= rx_pack::pi_ctl_t'(track_off[j]);
        end
        for (int k = 0; k < n_lanes; k++) begin
            pattern[k]    = track_base[k % 4];
            frame_code[k] = pattern[k];
        end
        drive_frame();
        acc = 0;
        for (int e = 1; e <= track_cycles; e++) begin
            @(posedge clk_adc);
            pol = (e % 2 == 0) ? 1 : -1;
            for (int k = 0; k < n_lanes; k++) begin
                frame_code[k] = pol * pattern[k];
            end
            drive_frame();
            acc_prev = acc;
            // frame driven 5 edges back reaches the accumulator now
            if (e > wait_edges) begin
                pol = ((e - 5) % 2 == 0) ? 1 : -1;
                acc = (acc + (frame_error(pol) >>> track_shift)) & 32'h00ff_ffff;
            end
            @(negedge clk_adc);
            check_value("ctl_valid_o", ctl_valid_o, e >= wait_edges);
            for (int j = 0; j < n_pi; j++) begin
                check_value($sformatf("pi_ctl_o[%0d]", j), pi_ctl_o[j],
                            pi_expect(acc_prev, track_sel[j], track_off[j]));
            end
        end
    endtask

    initial begin
        cdr_rstb     = 1'b0;
        en_cal_i     = 1'b0;
        ndiv_i       = '0;
        slice_lo_i   = '0;
        slice_mid_i  = '0;
        slice_hi_i   = '0;
        gain_shift_i = '0;
        for (int i = 0; i < n_lanes; i++) begin
            adc_mag_i[i]  = '0;
            adc_sign_i[i] = 1'b0;
        end
        for (int j = 0; j < n_pi; j++) begin
            max_sel_i[j]   = '0;
            pi_offset_i[j] = '0;
        end

        test_reset_wait();
        test_slice();
        test_cal();
        test_quiet();
        test_track();

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/rx_pack.sv
logic/adc_unfold_cal.sv
logic/adc_frontend.sv
logic/pam4_slicer.sv
logic/mm_cdr_loop.sv
logic/pi_ctl_map.sv
logic/rx_digital_core.sv
sim/rx_core_props.sv
sim/tb_rx_core.sv
